/* dot_product_unit.sv */
`include "mm_config.svh"

module dot_product_unit (
  input  logic                 clk_mem,
  input  logic                 reset,
  input  logic                 in_valid,
  input  mm_pkg::operand_row_t a_row,
  input  mm_pkg::operand_row_t b_col,
  output mm_pkg::acc_t         sum,
  output logic                 sum_valid
);

  localparam int PROD_WIDTH = 2 * `MM_EWIDTH;

  logic signed [PROD_WIDTH-1:0] prod_q [0:`MM_SIZE-1];
  logic                         prod_valid_q;
  mm_pkg::acc_t                 sum_next;

  //////////////////////////////
  // Stage one, lane products
  //////////////////////////////

  // Full width signed products, -128 * -128 still fits
  always_ff @(posedge clk_mem) begin
    for (int k = 0; k < `MM_SIZE; k++) begin
      prod_q[k] <= $signed(a_row[k]) * $signed(b_col[k]);
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid_q <= in_valid;
    end
  end

  //////////////////////////////
  // Stage two, adder tree
  //////////////////////////////

  // Sign extend each product before summing
  always_comb begin
    sum_next = '0;
    for (int k = 0; k < `MM_SIZE; k++) begin
      sum_next = sum_next + mm_pkg::acc_t'(prod_q[k]);
    end
  end

  always_ff @(posedge clk_mem) begin
    sum <= sum_next;
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid_q;
    end
  end

endmodule

/* files.f */
+incdir+.
mm_pkg.sv
row_bank.sv
dot_product_unit.sv
matmul_controller.sv
matmul_top.sv
tb_clock_gen.sv
matmul_props.sv
matmul_checker.sv
matmul_tb.sv

/* matmul_checker.sv */
`include "mm_config.svh"

module matmul_checker (
  input  logic                 clk_mem,
  input  logic                 reset,
  input  int                   test_id,
  input  logic                 load_en,
  input  logic                 load_to_b,
  input  mm_pkg::bank_addr_t   load_addr,
  input  mm_pkg::operand_row_t load_data,
  input  logic                 start,
  input  logic                 read_en,
  input  mm_pkg::bank_addr_t   read_addr,
  input  logic                 busy,
  input  logic                 done,
  input  mm_pkg::result_row_t  read_data,
  input  logic                 read_valid,
  output int                   error_count,
  output int                   check_count,
  output int                   done_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // A by [row][k], B by [column][k], C by [row][column]
  int                 a_model [`MM_SIZE][`MM_SIZE];
  int                 b_model [`MM_SIZE][`MM_SIZE];
  int                 c_model [`MM_SIZE][`MM_SIZE];
  logic [2:0]         read_pipe_valid;
  mm_pkg::bank_addr_t read_pipe_addr [3];
  logic               running;
  logic               after_reset;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_state";
      2: return "random_multiply";
      3: return "read_timing";
      4: return "reload_b";
      5: return "busy_ignore";
      6: return "extreme_values";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("[ERROR] %s %s expected %0d actual %0d",
               test_name(test_id), what, expected, actual);
    end
  endtask

  // C[i][j] is the signed sum over k of A[i][k] * B[k][j]
  task automatic compute_model();
    int acc;
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        acc = 0;
        for (int k = 0; k < `MM_SIZE; k++) begin
          acc += a_model[i][k] * b_model[j][k];
        end
        c_model[i][j] = acc;
      end
    end
  endtask

  task automatic check_row(input mm_pkg::bank_addr_t row);
    for (int j = 0; j < `MM_SIZE; j++) begin
      check_value($sformatf("C[%0d][%0d]", row, j), c_model[row][j], int'(read_data[j]));
    end
  endtask

  //////////////////////////////
  // Per cycle comparison
  //////////////////////////////

  always @(posedge clk_mem) begin
    if (reset) begin
      error_count     = 0;
      check_count     = 0;
      done_count      = 0;
      running         = 1'b0;
      read_pipe_valid = '0;
      after_reset     = 1'b1;
    end else begin
      if (after_reset) begin
        check_value("busy", 0, int'(busy));
        check_value("done", 0, int'(done));
        check_value("read_valid", 0, int'(read_valid));
      end
      after_reset = 1'b0;

      // A done pulse closes the multiply the model started
      if (done) begin
        done_count++;
        if (!running) begin
          error_count++;
          $display("Test %s saw a done pulse without an accepted start",
                   test_name(test_id));
        end else begin
          compute_model();
        end
        running = 1'b0;
      end

      // Busy from the edge after an accepted start until done
      check_value("busy", int'(running), int'(busy));

      // Accepted reads return exactly three cycles later
      check_value("read_valid", int'(read_pipe_valid[2]), int'(read_valid));
      if (read_valid && read_pipe_valid[2]) begin
        check_row(read_pipe_addr[2]);
      end
      read_pipe_addr[2] = read_pipe_addr[1];
      read_pipe_addr[1] = read_pipe_addr[0];
      read_pipe_addr[0] = read_addr;
      read_pipe_valid   = {read_pipe_valid[1:0], read_en & ~running};

      // Only requests sampled while idle reach the model
      if (load_en && !running) begin
        for (int k = 0; k < `MM_SIZE; k++) begin
          if (load_to_b) begin
            b_model[load_addr][k] = int'(load_data[k]);
          end else begin
            a_model[load_addr][k] = int'(load_data[k]);
          end
        end
      end
      if (start && !running) begin
        running = 1'b1;
      end
    end
  end

endmodule

/* matmul_controller.sv */
`include "mm_config.svh"

module matmul_controller (
  input  logic                 clk_mem,
  input  logic                 reset,
  input  logic                 load_en,
  input  logic                 load_to_b,
  input  logic                 read_en,
  input  logic                 start,
  input  mm_pkg::bank_addr_t   load_addr,
  input  mm_pkg::bank_addr_t   read_addr,
  input  mm_pkg::operand_row_t load_data,
  output logic                 busy,
  output logic                 done,
  output logic                 read_valid,
  output logic                 a_host_sel,
  output logic                 b_host_sel,
  output logic                 c_host_sel,
  output logic                 a_we,
  output logic                 b_we,
  output logic                 c_we,
  output mm_pkg::bank_addr_t   host_addr,
  output mm_pkg::bank_addr_t   a_eng_addr,
  output mm_pkg::bank_addr_t   b_eng_addr,
  output mm_pkg::bank_addr_t   c_eng_addr,
  output mm_pkg::operand_row_t op_wdata,
  output mm_pkg::result_row_t  c_wdata,
  output logic                 pair_valid,
  input  mm_pkg::acc_t         sum,
  input  logic                 sum_valid
);

  localparam int PAIR_BITS = 2 * `MM_AWIDTH;
  localparam int NUM_PAIRS = `MM_SIZE * `MM_SIZE;

  logic                  load_q;
  logic                  load_to_b_q;
  logic                  read_q;
  logic [1:0]            read_pipe;
  logic                  start_ok;
  logic                  issuing;
  logic [PAIR_BITS-1:0]  issue_cnt;
  logic [1:0]            issue_pipe;
  logic [PAIR_BITS-1:0]  retire_cnt;
  logic [`MM_AWIDTH-1:0] retire_lane;
  logic [`MM_AWIDTH-1:0] retire_row;
  logic                  c_last;

  //////////////////////////////
  // Host input registers
  //////////////////////////////

  // Anything sampled while busy is dropped here
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      load_q      <= 1'b0;
      load_to_b_q <= 1'b0;
      read_q      <= 1'b0;
      host_addr   <= '0;
    end else begin
      load_q      <= load_en & ~busy;
      load_to_b_q <= load_to_b;
      read_q      <= read_en & ~busy;
      host_addr   <= load_en ? load_addr : read_addr;
    end
  end

  always_ff @(posedge clk_mem) begin
    op_wdata <= load_data;
  end

  // One load enable steers both operand banks
  assign a_host_sel = load_q;
  assign b_host_sel = load_q;
  assign a_we       = load_q & ~load_to_b_q;
  assign b_we       = load_q & load_to_b_q;
  assign c_host_sel = read_q;

  // Bank address and bank read stages behind read_q
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      read_pipe <= '0;
    end else begin
      read_pipe <= {read_pipe[0], read_q};
    end
  end

  assign read_valid = read_pipe[1];

  //////////////////////////////
  // Pair sequencer
  //////////////////////////////

  assign start_ok = start & ~busy;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      busy      <= 1'b0;
      issuing   <= 1'b0;
      issue_cnt <= '0;
    end else if (start_ok) begin
      busy      <= 1'b1;
      issuing   <= 1'b1;
      issue_cnt <= '0;
    end else begin
      if (issuing) begin
        issue_cnt <= issue_cnt + 1'b1;
        if (issue_cnt == PAIR_BITS'(NUM_PAIRS - 1)) begin
          issuing <= 1'b0;
        end
      end
      // Falls on the same edge as done
      if (c_we && c_last) begin
        busy <= 1'b0;
      end
    end
  end

  // Row i from the upper bits, column j from the lower
  assign a_eng_addr = issue_cnt[PAIR_BITS-1:`MM_AWIDTH];
  assign b_eng_addr = issue_cnt[`MM_AWIDTH-1:0];

  // Match the two cycle bank read
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      issue_pipe <= '0;
    end else begin
      issue_pipe <= {issue_pipe[0], issuing};
    end
  end

  assign pair_valid = issue_pipe[1];

  //////////////////////////////
  // Result packing
  //////////////////////////////

  // Sums retire in issue order, so the count gives row and lane
  assign retire_lane = retire_cnt[`MM_AWIDTH-1:0];
  assign retire_row  = retire_cnt[PAIR_BITS-1:`MM_AWIDTH];

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      retire_cnt <= '0;
      c_we       <= 1'b0;
      c_last     <= 1'b0;
      c_eng_addr <= '0;
      done       <= 1'b0;
    end else begin
      c_we <= 1'b0;
      done <= c_we & c_last;
      if (sum_valid) begin
        retire_cnt <= retire_cnt + 1'b1;
        if (retire_lane == `MM_AWIDTH'(`MM_SIZE - 1)) begin
          c_we       <= 1'b1;
          c_eng_addr <= retire_row;
          c_last     <= (retire_cnt == PAIR_BITS'(NUM_PAIRS - 1));
        end
      end
    end
  end

  // Lane 3 lands together with the write strobe
  always_ff @(posedge clk_mem) begin
    if (sum_valid) begin
      c_wdata[retire_lane] <= sum;
    end
  end

endmodule

/* matmul_props.sv */
module matmul_props (
  input logic clk_mem,
  input logic reset,
  input logic busy,
  input logic done,
  input logic read_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  //////////////////////////////
  // Start and done control
  //////////////////////////////

  done_one_cycle_a: assert property (@(posedge clk_mem) disable iff (reset)
    done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_count++;
    end

  // Busy was still high on the edge that raised done
  done_while_busy_a: assert property (@(posedge clk_mem) disable iff (reset)
    done |-> $past(busy))
    else begin
      $error("done rose while the controller was idle");
      fail_count++;
    end

  busy_falls_with_done_a: assert property (@(posedge clk_mem) disable iff (reset)
    $fell(busy) == done)
    else begin
      $error("busy and done did not change on the same edge");
      fail_count++;
    end

  //////////////////////////////
  // Read path
  //////////////////////////////

  no_read_while_busy_a: assert property (@(posedge clk_mem) disable iff (reset)
    busy |-> !read_valid)
    else begin
      $error("read_valid was high during a multiply");
      fail_count++;
    end

endmodule

/* matmul_tb.sv */
`include "mm_config.svh"

module matmul_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 2000;

  logic                 clk_mem;
  logic                 reset;
  logic                 load_en;
  logic                 load_to_b;
  mm_pkg::bank_addr_t   load_addr;
  mm_pkg::operand_row_t load_data;
  logic                 start;
  logic                 read_en;
  mm_pkg::bank_addr_t   read_addr;
  logic                 busy;
  logic                 done;
  mm_pkg::result_row_t  read_data;
  logic                 read_valid;
  int                   test_id;
  int                   error_count;
  int                   check_count;
  int                   done_count;
  int                   assert_fails;
  int                   seed;
  int                   cycle_count = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clk_mem (clk_mem),
    .reset   (reset)
  );

  matmul_top matmul_top_inst (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .load_en    (load_en),
    .load_to_b  (load_to_b),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .start      (start),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .busy       (busy),
    .done       (done),
    .read_data  (read_data),
    .read_valid (read_valid)
  );

  matmul_checker matmul_checker_inst (
    .clk_mem     (clk_mem),
    .reset       (reset),
    .test_id     (test_id),
    .load_en     (load_en),
    .load_to_b   (load_to_b),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .start       (start),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .busy        (busy),
    .done        (done),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .error_count (error_count),
    .check_count (check_count),
    .done_count  (done_count)
  );

  bind matmul_controller matmul_props matmul_props_inst (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .busy       (busy),
    .done       (done),
    .read_valid (read_valid)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic int random_int();
    return $random(seed);
  endfunction

  function automatic mm_pkg::operand_row_t random_row();
    mm_pkg::operand_row_t row;
    for (int k = 0; k < `MM_SIZE; k++) begin
      row[k] = mm_pkg::element_t'(random_int());
    end
    return row;
  endfunction

  function automatic mm_pkg::operand_row_t const_row(input int value);
    mm_pkg::operand_row_t row;
    for (int k = 0; k < `MM_SIZE; k++) begin
      row[k] = mm_pkg::element_t'(value);
    end
    return row;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk_mem);
  endtask

  task automatic load_row(input logic to_b, input int addr, input mm_pkg::operand_row_t data);
    @(posedge clk_mem);
    load_en   <= 1'b1;
    load_to_b <= to_b;
    load_addr <= mm_pkg::bank_addr_t'(addr);
    load_data <= data;
    @(posedge clk_mem);
    load_en <= 1'b0;
  endtask

  task automatic load_random_matrix(input logic to_b);
    for (int r = 0; r < `MM_SIZE; r++) begin
      load_row(to_b, r, random_row());
    end
  endtask

  task automatic load_const_matrix(input logic to_b, input int value);
    for (int r = 0; r < `MM_SIZE; r++) begin
      load_row(to_b, r, const_row(value));
    end
  endtask

  // Requests that a busy DUT must drop
  task automatic drive_junk(input int cycles);
    repeat (cycles) begin
      @(posedge clk_mem);
      load_en   <= 1'b1;
      load_to_b <= 1'(random_int());
      load_addr <= mm_pkg::bank_addr_t'(random_int());
      load_data <= random_row();
      start     <= 1'b1;
      read_en   <= 1'b1;
      read_addr <= mm_pkg::bank_addr_t'(random_int());
    end
    @(posedge clk_mem);
    load_en <= 1'b0;
    start   <= 1'b0;
    read_en <= 1'b0;
  endtask

  task automatic run_multiply(input logic with_junk);
    @(posedge clk_mem);
    start <= 1'b1;
    @(posedge clk_mem);
    start <= 1'b0;
    if (with_junk) begin
      drive_junk(12);
    end
    // Cycle watchdog below bounds this wait
    while (done !== 1'b1) @(posedge clk_mem);
  endtask

  task automatic read_rows(input logic back_to_back);
    for (int r = 0; r < `MM_SIZE; r++) begin
      @(posedge clk_mem);
      read_en   <= 1'b1;
      read_addr <= mm_pkg::bank_addr_t'(r);
      if (!back_to_back) begin
        @(posedge clk_mem);
        read_en <= 1'b0;
      end
    end
    @(posedge clk_mem);
    read_en <= 1'b0;
    // Let the last word drain before anything else starts
    idle(4);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed = 32'h43a9c7df;
    load_en   <= 1'b0;
    load_to_b <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    start     <= 1'b0;
    read_en   <= 1'b0;
    read_addr <= '0;
    test_id   <= 1;
    @(posedge clk_mem);
    while (reset) @(posedge clk_mem);
    idle(3);

    test_id <= 2;
    repeat (3) begin
      load_random_matrix(1'b0);
      load_random_matrix(1'b1);
      run_multiply(1'b0);
      read_rows(1'b0);
    end

    test_id <= 3;
    read_rows(1'b1);
    read_rows(1'b1);

    // A stays from the previous multiply
    test_id <= 4;
    load_random_matrix(1'b1);
    run_multiply(1'b0);
    read_rows(1'b1);

    test_id <= 5;
    load_random_matrix(1'b0);
    load_random_matrix(1'b1);
    run_multiply(1'b1);
    read_rows(1'b1);

    test_id <= 6;
    load_const_matrix(1'b0, -128);
    load_const_matrix(1'b1, -128);
    run_multiply(1'b0);
    read_rows(1'b1);
    load_const_matrix(1'b1, 127);
    run_multiply(1'b0);
    read_rows(1'b1);
    load_const_matrix(1'b0, 127);
    run_multiply(1'b0);
    read_rows(1'b1);

    idle(4);
    assert_fails = matmul_top_inst.matmul_controller_inst.matmul_props_inst.fail_count;
    $display("Checks: %0d, done pulses: %0d, errors: %0d, assertion failures: %0d",
             check_count, done_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  always @(posedge clk_mem) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles, errors so far: %0d",
               MAX_CYCLES, error_count);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

/* matmul_top.sv */
`include "mm_config.svh"

module matmul_top (
  input  logic                 clk_mem,
  input  logic                 reset,
  input  logic                 load_en,
  input  logic                 load_to_b,
  input  mm_pkg::bank_addr_t   load_addr,
  input  mm_pkg::operand_row_t load_data,
  input  logic                 start,
  input  logic                 read_en,
  input  mm_pkg::bank_addr_t   read_addr,
  output logic                 busy,
  output logic                 done,
  output mm_pkg::result_row_t  read_data,
  output logic                 read_valid
);

  // Bank steering from the controller
  logic                 a_host_sel;
  logic                 b_host_sel;
  logic                 c_host_sel;
  logic                 a_we;
  logic                 b_we;
  logic                 c_we;
  mm_pkg::bank_addr_t   host_addr;
  mm_pkg::bank_addr_t   a_eng_addr;
  mm_pkg::bank_addr_t   b_eng_addr;
  mm_pkg::bank_addr_t   c_eng_addr;
  mm_pkg::operand_row_t op_wdata;
  mm_pkg::result_row_t  c_wdata;

  // Datapath between the banks and the dot product
  mm_pkg::operand_row_t a_row;
  mm_pkg::operand_row_t b_col;
  logic                 pair_valid;
  mm_pkg::acc_t         sum;
  logic                 sum_valid;

  //////////////////////////////
  // Control
  //////////////////////////////

  matmul_controller matmul_controller_inst (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .load_en    (load_en),
    .load_to_b  (load_to_b),
    .read_en    (read_en),
    .start      (start),
    .load_addr  (load_addr),
    .read_addr  (read_addr),
    .load_data  (load_data),
    .busy       (busy),
    .done       (done),
    .read_valid (read_valid),
    .a_host_sel (a_host_sel),
    .b_host_sel (b_host_sel),
    .c_host_sel (c_host_sel),
    .a_we       (a_we),
    .b_we       (b_we),
    .c_we       (c_we),
    .host_addr  (host_addr),
    .a_eng_addr (a_eng_addr),
    .b_eng_addr (b_eng_addr),
    .c_eng_addr (c_eng_addr),
    .op_wdata   (op_wdata),
    .c_wdata    (c_wdata),
    .pair_valid (pair_valid),
    .sum        (sum),
    .sum_valid  (sum_valid)
  );

  //////////////////////////////
  // Operand banks
  //////////////////////////////

  // Rows of A
  row_bank #(
    .word_t (mm_pkg::operand_row_t)
  ) a_bank (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .host_sel  (a_host_sel),
    .host_addr (host_addr),
    .eng_addr  (a_eng_addr),
    .we        (a_we),
    .wdata     (op_wdata),
    .rdata     (a_row)
  );

  // Columns of B, stored one per row slot
  row_bank #(
    .word_t (mm_pkg::operand_row_t)
  ) b_bank (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .host_sel  (b_host_sel),
    .host_addr (host_addr),
    .eng_addr  (b_eng_addr),
    .we        (b_we),
    .wdata     (op_wdata),
    .rdata     (b_col)
  );

  //////////////////////////////
  // Compute and result
  //////////////////////////////

  dot_product_unit dot_product_unit_inst (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .in_valid  (pair_valid),
    .a_row     (a_row),
    .b_col     (b_col),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  // Engine writes C rows, host reads them back
  row_bank #(
    .word_t (mm_pkg::result_row_t)
  ) c_bank (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .host_sel  (c_host_sel),
    .host_addr (host_addr),
    .eng_addr  (c_eng_addr),
    .we        (c_we),
    .wdata     (c_wdata),
    .rdata     (read_data)
  );

endmodule

/* mm_config.svh */
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

//////////////////////////////
// Matrix geometry
//////////////////////////////

// Rows and columns per matrix, also the depth of every bank
`define MM_SIZE 4

// Row address into a bank
`define MM_AWIDTH 2

//////////////////////////////
// Arithmetic widths
//////////////////////////////

// Signed operand element
`define MM_EWIDTH 8

// Holds four full products plus headroom
`define MM_ACC_WIDTH 20

`endif

/* mm_pkg.sv */
`include "mm_config.svh"

package mm_pkg;

  //////////////////////////////
  // Operand side
  //////////////////////////////

  // One matrix element
  typedef logic signed [`MM_EWIDTH-1:0] element_t;

  // One A row or one B column, lane k is element k
  typedef element_t [`MM_SIZE-1:0] operand_row_t;

  //////////////////////////////
  // Result side
  //////////////////////////////

  // One dot product
  typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

  // One C row, lane j is column j
  typedef acc_t [`MM_SIZE-1:0] result_row_t;

  //////////////////////////////
  // Addressing
  //////////////////////////////

  typedef logic [`MM_AWIDTH-1:0] bank_addr_t;

endpackage

/* row_bank.sv */
`include "mm_config.svh"

module row_bank #(
  parameter type word_t = logic
) (
  input  logic               clk_mem,
  input  logic               reset,
  input  logic               host_sel,
  input  mm_pkg::bank_addr_t host_addr,
  input  mm_pkg::bank_addr_t eng_addr,
  input  logic               we,
  input  word_t              wdata,
  output word_t              rdata
);

  word_t              mem [0:`MM_SIZE-1];
  mm_pkg::bank_addr_t addr_q;
  logic               we_q;
  word_t              wdata_q;

  // Host or engine address, registered with the write strobe
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end else begin
      addr_q <= host_sel ? host_addr : eng_addr;
      we_q   <= we;
    end
  end

  always_ff @(posedge clk_mem) begin
    wdata_q <= wdata;
  end

  // Single port array, read word registered
  always_ff @(posedge clk_mem) begin
    if (we_q) begin
      mem[addr_q] <= wdata_q;
    end
    rdata <= mem[addr_q];
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the matmul testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module matmul_tb -f files.f -o matmul_sim; then
  echo "Verilator build failed"
  exit 1
fi

# Assertion failures are counted by the testbench, so let the run continue past them
sim_output=$(./obj_dir/matmul_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qxF "All tests passed!"; then
  exit 0
fi
exit 1

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_mem,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;

  // 8 ns period
  initial begin
    clk_mem = 1'b0;
    forever #4 clk_mem = ~clk_mem;
  end

  // Reset released on a rising edge after 8 cycles
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_mem);
    reset <= 1'b0;
  end

endmodule
